//--- rv_decode_top.f
+incdir+rtl
+incdir+tb
rtl/rv_decode_pkg.sv
rtl/rv_stage_reg.sv
rtl/rv_operand_decode.sv
rtl/rv_ctrl_decode.sv
rtl/rv_csr_decode.sv
rtl/rv_decode_top.sv
tb/tb_rv_decode_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_rv_decode_top
FILELIST  = rv_decode_top.f

SRCS = $(wildcard rtl/*.sv rtl/*.svh tb/*.sv tb/*.svh)
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out=$$(./$(BIN) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

//--- tb/tb_rv_decode_vectors.svh
`ifndef TB_RV_DECODE_VECTORS_SVH
`define TB_RV_DECODE_VECTORS_SVH

// columns: name, instr, compressed, rs1, rs2, rd, csr {idx, imm, imm_sel, w/s/c/r}
// then ctrl {alu_res, alu_sub, funct3, res_src, op1, op2 r/i/j, reg_write, kind flags, supported}

string          vec_name[$];
logic [31:0]    vec_instr[$];
logic           vec_comp[$];
logic [4:0]     vec_rs1[$];
logic [4:0]     vec_rs2[$];
logic [4:0]     vec_rd[$];
dec_csr_t       vec_csr[$];
dec_ctrl_t      vec_ctrl[$];

task automatic add_vec(string name, logic [31:0] instr, logic comp, logic [4:0] rs1,
                       logic [4:0] rs2, logic [4:0] rd, dec_csr_t csr, dec_ctrl_t ctrl);
    vec_name.push_back(name);
    vec_instr.push_back(instr);
    vec_comp.push_back(comp);
    vec_rs1.push_back(rs1);
    vec_rs2.push_back(rs2);
    vec_rd.push_back(rd);
    vec_csr.push_back(csr);
    vec_ctrl.push_back(ctrl);
endtask

task automatic fill_vectors();
    add_vec("lui", 32'h123450B7, 1'b0, 5'd0, 5'd3, 5'd1, {12'h123, 5'd8, 1'b1, 4'b0000},
            {4'b0000, 5'b00000, 3'b101, 3'b001, 1'b0, 3'b010, 1'b1, 7'b0000000, 1'b1});
    add_vec("auipc", 32'h00001097, 1'b0, 5'd0, 5'd0, 5'd1, {12'h000, 5'd0, 1'b0, 4'b0000},
            {4'b0000, 5'b00000, 3'b001, 3'b001, 1'b1, 3'b010, 1'b1, 7'b0000000, 1'b1});
    add_vec("jal", 32'h008000EF, 1'b0, 5'd0, 5'd8, 5'd1, {12'h008, 5'd0, 1'b0, 4'b0000},
            {4'b0000, 5'b00000, 3'b000, 3'b010, 1'b1, 3'b001, 1'b1, 7'b1000000, 1'b1});
    add_vec("jalr", 32'h004100E7, 1'b0, 5'd2, 5'd4, 5'd1, {12'h004, 5'd2, 1'b0, 4'b0000},
            {4'b0000, 5'b00000, 3'b000, 3'b010, 1'b0, 3'b010, 1'b1, 7'b0100000, 1'b1});
    add_vec("beq", 32'h00310863, 1'b0, 5'd2, 5'd3, 5'd16, {12'h003, 5'd2, 1'b0, 4'b0000},
            {4'b1000, 5'b10000, 3'b000, 3'b001, 1'b0, 3'b100, 1'b0, 7'b0010000, 1'b1});
    add_vec("bltu", 32'h00316863, 1'b0, 5'd2, 5'd3, 5'd16, {12'h003, 5'd2, 1'b1, 4'b0000},
            {4'b1000, 5'b10110, 3'b110, 3'b001, 1'b0, 3'b100, 1'b0, 7'b0010000, 1'b1});
    add_vec("lw", 32'h00812083, 1'b0, 5'd2, 5'd8, 5'd1, {12'h008, 5'd2, 1'b0, 4'b0000},
            {4'b0001, 5'b00000, 3'b010, 3'b100, 1'b0, 3'b010, 1'b1, 7'b0000000, 1'b1});
    add_vec("sw", 32'h00312623, 1'b0, 5'd2, 5'd3, 5'd12, {12'h003, 5'd2, 1'b0, 4'b0000},
            {4'b0001, 5'b00000, 3'b010, 3'b001, 1'b0, 3'b010, 1'b0, 7'b0001000, 1'b1});
    add_vec("addi", 32'hFFB10093, 1'b0, 5'd2, 5'd27, 5'd1, {12'hFFB, 5'd2, 1'b0, 4'b0000},
            {4'b0000, 5'b00000, 3'b000, 3'b001, 1'b0, 3'b010, 1'b1, 7'b0000000, 1'b1});
    add_vec("srai", 32'h40715093, 1'b0, 5'd2, 5'd7, 5'd1, {12'h407, 5'd2, 1'b1, 4'b0000},
            {4'b0010, 5'b10101, 3'b101, 3'b001, 1'b0, 3'b010, 1'b1, 7'b0000000, 1'b1});
    add_vec("add", 32'h003100B3, 1'b0, 5'd2, 5'd3, 5'd1, {12'h003, 5'd2, 1'b0, 4'b0000},
            {4'b0001, 5'b00000, 3'b000, 3'b001, 1'b0, 3'b100, 1'b1, 7'b0000000, 1'b1});
    add_vec("sub", 32'h403100B3, 1'b0, 5'd2, 5'd3, 5'd1, {12'h403, 5'd2, 1'b0, 4'b0000},
            {4'b0001, 5'b10000, 3'b000, 3'b001, 1'b0, 3'b100, 1'b1, 7'b0000000, 1'b1});
    add_vec("sltu", 32'h003130B3, 1'b0, 5'd2, 5'd3, 5'd1, {12'h003, 5'd2, 1'b0, 4'b0000},
            {4'b1000, 5'b10011, 3'b011, 3'b001, 1'b0, 3'b100, 1'b1, 7'b0000000, 1'b1});
    add_vec("xor", 32'h003140B3, 1'b0, 5'd2, 5'd3, 5'd1, {12'h003, 5'd2, 1'b1, 4'b0000},
            {4'b0100, 5'b00100, 3'b100, 3'b001, 1'b0, 3'b100, 1'b1, 7'b0000000, 1'b1});
    add_vec("ecall", 32'h00000073, 1'b0, 5'd0, 5'd0, 5'd0, {12'h000, 5'd0, 1'b0, 4'b0000},
            {4'b0000, 5'b00000, 3'b000, 3'b001, 1'b0, 3'b100, 1'b1, 7'b0000000, 1'b1});
    add_vec("ebreak", 32'h00100073, 1'b0, 5'd0, 5'd1, 5'd0, {12'h001, 5'd0, 1'b0, 4'b0000},
            {4'b0000, 5'b00000, 3'b000, 3'b001, 1'b0, 3'b100, 1'b1, 7'b0000010, 1'b1});
    add_vec("csrrw", 32'h300110F3, 1'b0, 5'd2, 5'd0, 5'd1, {12'h300, 5'd2, 1'b0, 4'b1001},
            {4'b0000, 5'b00001, 3'b001, 3'b001, 1'b0, 3'b100, 1'b1, 7'b0000001, 1'b1});
    add_vec("csrrsi", 32'h3412E0F3, 1'b0, 5'd5, 5'd1, 5'd1, {12'h341, 5'd5, 1'b1, 4'b0101},
            {4'b0000, 5'b00110, 3'b110, 3'b001, 1'b0, 3'b100, 1'b1, 7'b0000001, 1'b1});
    add_vec("csrrc", 32'h305130F3, 1'b0, 5'd2, 5'd5, 5'd1, {12'h305, 5'd2, 1'b0, 4'b0011},
            {4'b0000, 5'b00011, 3'b011, 3'b001, 1'b0, 3'b100, 1'b1, 7'b0000001, 1'b1});
    add_vec("mret", 32'h30200073, 1'b0, 5'd0, 5'd2, 5'd0, {12'h302, 5'd0, 1'b0, 4'b0000},
            {4'b0000, 5'b00000, 3'b000, 3'b001, 1'b0, 3'b100, 1'b1, 7'b0000100, 1'b1});
    // custom-0 opcode, not supported
    add_vec("custom0", 32'h0000000B, 1'b0, 5'd0, 5'd0, 5'd0, {12'h000, 5'd0, 1'b0, 4'b0000},
            {4'b0000, 5'b00000, 3'b000, 3'b001, 1'b0, 3'b100, 1'b1, 7'b0000000, 1'b0});
    add_vec("c.li", 32'h00004501, 1'b1, 5'd0, 5'd0, 5'd10, {12'h000, 5'd0, 1'b1, 4'b0000},
            {4'b0000, 5'b00100, 3'b010, 3'b001, 1'b0, 3'b100, 1'b0, 7'b0000000, 1'b0});
endtask

`endif

//--- tb/tb_rv_decode_top.sv
`timescale 1ns/100ps

`include "rv_decode_params.svh"

module tb_rv_decode_top
    import rv_decode_pkg::*;
;

    localparam int VALID_TIMEOUT = 8;
    localparam int SIM_CYCLES    = 20000;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_valid;
    logic       i_stall;
    logic       i_flush;
    fetch_t     i_fetch;
    logic       o_valid;
    dec_ctrl_t  o_ctrl;
    dec_oper_t  o_oper;
    dec_csr_t   o_csr;

    logic [31:0] lcg_state = 32'd51344;

    `include "tb_rv_decode_vectors.svh"

    rv_decode_top i_dut (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_fetch    (i_fetch),
        .o_valid    (o_valid),
        .o_ctrl     (o_ctrl),
        .o_oper     (o_oper),
        .o_csr      (o_csr)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    initial
    begin
        repeat (SIM_CYCLES) @(posedge i_clk);
        $display("simulation did not finish within %0d cycles", SIM_CYCLES);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // RISC-V immediate formats
    function automatic logic [31:0] fmt_i(logic [31:0] w);
        return {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic logic [31:0] fmt_s(logic [31:0] w);
        return {{20{w[31]}}, w[31:25], w[11:7]};
    endfunction

    function automatic logic [31:0] fmt_b(logic [31:0] w);
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] fmt_u(logic [31:0] w);
        return {w[31:12], 12'h000};
    endfunction

    function automatic logic [31:0] fmt_j(logic [31:0] w);
        return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic dec_oper_t expect_oper(logic [31:0] w, logic [31:0] pc, logic bp,
                                              logic comp, logic [4:0] rs1, logic [4:0] rs2,
                                              logic [4:0] rd);
        dec_oper_t  e;
        logic [4:0] opc;
        logic       full;
        opc  = w[6:2];
        full = (w[1:0] == 2'b11);
        e.rs1 = rs1;
        e.rs2 = rs2;
        e.rd  = rd;
        if (full && (opc == `RV_OPC_LUI || opc == `RV_OPC_AUIPC))
            e.imm_i = fmt_u(w);
        else if (full && opc == `RV_OPC_STORE)
            e.imm_i = fmt_s(w);
        else
            e.imm_i = fmt_i(w);
        e.imm_j = (full && opc == `RV_OPC_JAL) ? fmt_j(w) : fmt_b(w);
        e.pc          = pc;
        e.pc_next     = comp ? pc + 32'd2 : pc + 32'd4;
        e.branch_pred = bp;
        return e;
    endfunction

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping on first failure");
    endtask

    task automatic check_valid(logic got, logic exp, string what);
        if (got !== exp)
        begin
            $display("error at %0t: %s o_valid got %b expected %b", $time, what, got, exp);
            report_fail("o_valid mismatch");
        end
    endtask

    task automatic check_ctrl(dec_ctrl_t got, dec_ctrl_t exp, string what);
        if (got !== exp)
        begin
            $display("error at %0t: %s o_ctrl got %b expected %b", $time, what, got, exp);
            report_fail("o_ctrl mismatch");
        end
    endtask

    task automatic check_oper(dec_oper_t got, dec_oper_t exp, string what);
        if (got !== exp)
        begin
            $display("error at %0t: %s o_oper got %h expected %h", $time, what, got, exp);
            report_fail("o_oper mismatch");
        end
    endtask

    task automatic check_csr(dec_csr_t got, dec_csr_t exp, string what);
        if (got !== exp)
        begin
            $display("error at %0t: %s o_csr got %h expected %h", $time, what, got, exp);
            report_fail("o_csr mismatch");
        end
    endtask

    // called on a falling edge so the input goes in at the next rising edge
    task automatic drive_fetch(logic [31:0] w, logic [31:0] pc, logic bp, logic comp);
        i_valid               = 1'b1;
        i_fetch.instr         = w;
        i_fetch.pc            = pc;
        i_fetch.branch_pred   = bp;
        i_fetch.is_compressed = comp;
    endtask

    task automatic wait_valid(string what);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge i_clk);
            i_valid = 1'b0;
            cycles++;
        end
        while (!o_valid && cycles < VALID_TIMEOUT);
        if (!o_valid)
            report_fail($sformatf("timeout: o_valid never rose for %s", what));
        if (cycles != 1)
            report_fail($sformatf("%s took %0d cycles instead of one", what, cycles));
    endtask

    task automatic check_entry(int k, logic [31:0] pc, logic bp);
        check_valid(o_valid, 1'b1, vec_name[k]);
        check_ctrl(o_ctrl, vec_ctrl[k], vec_name[k]);
        check_oper(o_oper, expect_oper(vec_instr[k], pc, bp, vec_comp[k], vec_rs1[k],
                                       vec_rs2[k], vec_rd[k]), vec_name[k]);
        check_csr(o_csr, vec_csr[k], vec_name[k]);
    endtask

    initial
    begin
        logic [31:0]    w;
        logic [31:0]    pc;
        logic [31:0]    r;
        logic           comp;
        logic [4:0]     rs1;
        dec_oper_t      exp_oper;

        i_rst_n = 1'b0;
        // a valid input during reset must not reach the output
        i_valid = 1'b1;
        i_stall = 1'b0;
        i_flush = 1'b0;
        i_fetch = '0;
        fill_vectors();

        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        check_valid(o_valid, 1'b0, "during reset");
        i_rst_n = 1'b1;
        i_valid = 1'b0;

        // idle after reset
        repeat (5)
        begin
            @(negedge i_clk);
            check_valid(o_valid, 1'b0, "idle after reset");
        end

        for (int k = 0; k < vec_instr.size(); k++)
        begin
            pc = 32'h0000_1000 + 32'(k * 8);
            drive_fetch(vec_instr[k], pc, k[0], vec_comp[k]);
            wait_valid(vec_name[k]);
            check_entry(k, pc, k[0]);
        end

        // random addi, sw, lui and jal words
        for (int n = 0; n < 20; n++)
        begin
            w = lcg_next();
            r = lcg_next();
            case (r[31:30])
                2'd0:
                begin
                    w[6:0]   = 7'h13;
                    w[14:12] = 3'b000;
                end
                2'd1:
                begin
                    w[6:0]   = 7'h23;
                    w[14:12] = 3'b010;
                end
                2'd2:
                    w[6:0] = 7'h37;
                default:
                    w[6:0] = 7'h6F;
            endcase
            pc   = lcg_next() & 32'hFFFF_FFFE;
            comp = r[7];
            rs1  = (w[6:0] == 7'h37) ? 5'd0 : w[19:15];
            exp_oper = expect_oper(w, pc, r[3], comp, rs1, w[24:20], w[11:7]);
            drive_fetch(w, pc, r[3], comp);
            wait_valid("random word");
            check_oper(o_oper, exp_oper, "random word");
        end

        // back-pressure holds the lsu entry while the next one waits
        drive_fetch(vec_instr[6], 32'h2000, 1'b0, vec_comp[6]);
        wait_valid("stall setup");
        drive_fetch(vec_instr[10], 32'h2004, 1'b1, vec_comp[10]);
        i_stall = 1'b1;
        repeat (3)
        begin
            @(negedge i_clk);
            check_entry(6, 32'h2000, 1'b0);
        end
        i_stall = 1'b0;
        wait_valid("stall release");
        check_entry(10, 32'h2004, 1'b1);

        // flush together with stall
        drive_fetch(vec_instr[0], 32'h3000, 1'b0, vec_comp[0]);
        wait_valid("flush setup");
        drive_fetch(vec_instr[1], 32'h3004, 1'b0, vec_comp[1]);
        i_stall = 1'b1;
        i_flush = 1'b1;
        @(negedge i_clk);
        check_valid(o_valid, 1'b0, "flush with stall");
        i_stall = 1'b0;
        @(negedge i_clk);
        check_valid(o_valid, 1'b0, "flush with new input");
        i_flush = 1'b0;
        i_valid = 1'b0;
        @(negedge i_clk);
        check_valid(o_valid, 1'b0, "idle after flush");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- rtl/rv_decode_top.sv
`timescale 1ns/100ps

module rv_decode_top
    import rv_decode_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_valid,
    input  logic        i_stall,
    input  logic        i_flush,
    input  fetch_t      i_fetch,
    output logic        o_valid,
    output dec_ctrl_t   o_ctrl,
    output dec_oper_t   o_oper,
    output dec_csr_t    o_csr
);

    dec_ctrl_t  ctrl;
    dec_oper_t  oper;
    dec_csr_t   csr;

    rv_operand_decode u_operand_decode (
        .i_fetch    (i_fetch),
        .o_oper     (oper)
    );

    rv_ctrl_decode u_ctrl_decode (
        .i_fetch    (i_fetch),
        .o_ctrl     (ctrl)
    );

    rv_csr_decode u_csr_decode (
        .i_fetch    (i_fetch),
        .o_csr      (csr)
    );

    // o_valid comes from the ctrl copy
    rv_stage_reg #(.payload_t(dec_ctrl_t)) u_ctrl_reg (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_data     (ctrl),
        .o_valid    (o_valid),
        .o_data     (o_ctrl)
    );

    rv_stage_reg #(.payload_t(dec_oper_t)) u_oper_reg (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_data     (oper),
        .o_valid    (),
        .o_data     (o_oper)
    );

    rv_stage_reg #(.payload_t(dec_csr_t)) u_csr_reg (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_data     (csr),
        .o_valid    (),
        .o_data     (o_csr)
    );

endmodule

//--- rtl/rv_csr_decode.sv
`timescale 1ns/100ps

`include "rv_decode_params.svh"

module rv_csr_decode
    import rv_decode_pkg::*;
(
    input  fetch_t      i_fetch,
    output dec_csr_t    o_csr
);

    logic [2:0] funct3;
    logic       grp_sys;

    assign funct3  = i_fetch.instr[14:12];
    assign grp_sys = (i_fetch.instr[1:0] == `RV_OPC_FULL)
                   & (i_fetch.instr[6:2] == `RV_OPC_SYSTEM);

    always_comb
    begin
        o_csr.idx     = i_fetch.instr[31:20];
        // rs1 field doubles as the 5-bit immediate
        o_csr.imm     = i_fetch.instr[19:15];
        o_csr.imm_sel = funct3[2];

        o_csr.write = grp_sys & (funct3[1:0] == 2'b01);
        o_csr.set   = grp_sys & (funct3[1:0] == 2'b10);
        o_csr.clear = grp_sys & (funct3[1:0] == 2'b11);
        // ecall/ebreak/mret have funct3 zero and never touch a csr
        o_csr.read  = grp_sys & (funct3 != 3'b000);

        // csr file applies exactly one modify op per access
        assert ($onehot0({o_csr.write, o_csr.set, o_csr.clear}))
            else $error("more than one csr modify strobe");
    end

endmodule

//--- rtl/rv_ctrl_decode.sv
`timescale 1ns/100ps

`include "rv_decode_params.svh"

module rv_ctrl_decode
    import rv_decode_pkg::*;
(
    input  fetch_t      i_fetch,
    output dec_ctrl_t   o_ctrl
);

    logic [4:0]     opc;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    logic [11:0]    funct12;
    logic           full;

    logic           grp_load;
    logic           grp_store;
    logic           grp_ari;
    logic           grp_arr;
    logic           grp_arr_ex;
    logic           grp_branch;
    logic           grp_sys;

    logic           inst_lui;
    logic           inst_auipc;
    logic           inst_jal;
    logic           inst_jalr;
    logic           inst_add;
    logic           inst_sub;
    logic           inst_sra;
    logic           inst_srai;
    logic           inst_ecall;
    logic           inst_ebreak;
    logic           inst_mret;
    logic           inst_csr_req;
    logic           ari_cmp;
    logic           arr_cmp;
    logic           f3_bits;
    logic           no_f3;

    assign opc     = i_fetch.instr[6:2];
    assign funct3  = i_fetch.instr[14:12];
    assign funct7  = i_fetch.instr[31:25];
    assign funct12 = i_fetch.instr[31:20];
    assign full    = (i_fetch.instr[1:0] == `RV_OPC_FULL);

    assign grp_load   = full & (opc == `RV_OPC_LOAD);
    assign grp_store  = full & (opc == `RV_OPC_STORE);
    assign grp_ari    = full & (opc == `RV_OPC_OP_IMM);
    assign grp_arr    = full & (opc == `RV_OPC_OP) & (funct7 == 7'b0000000);
    assign grp_arr_ex = full & (opc == `RV_OPC_OP) & (funct7 == 7'b0100000);
    assign grp_branch = full & (opc == `RV_OPC_BRANCH);
    assign grp_sys    = full & (opc == `RV_OPC_SYSTEM);

    assign inst_lui     = full & (opc == `RV_OPC_LUI);
    assign inst_auipc   = full & (opc == `RV_OPC_AUIPC);
    assign inst_jal     = full & (opc == `RV_OPC_JAL);
    assign inst_jalr    = full & (opc == `RV_OPC_JALR) & (funct3 == 3'b000);
    assign inst_add     = grp_arr & (funct3 == 3'b000);
    assign inst_sub     = grp_arr_ex & (funct3 == 3'b000);
    assign inst_sra     = grp_arr_ex & (funct3 == 3'b101);
    assign inst_srai    = grp_ari & (funct3 == 3'b101) & (funct7 == 7'b0100000);
    assign inst_ecall   = grp_sys & (funct3 == 3'b000) & (funct12 == `RV_F12_ECALL);
    assign inst_ebreak  = grp_sys & (funct3 == 3'b000) & (funct12 == `RV_F12_EBREAK);
    assign inst_mret    = grp_sys & (funct3 == 3'b000) & (funct12 == `RV_F12_MRET);
    assign inst_csr_req = grp_sys & (funct3 != 3'b000);

    // slt/sltu forms, and xor/or/and
    assign ari_cmp = grp_ari & (funct3[2:1] == 2'b01);
    assign arr_cmp = grp_arr & (funct3[2:1] == 2'b01);
    assign f3_bits = funct3[2] & (funct3[1:0] != 2'b01);

    // classes that run the alu as a plain adder
    assign no_f3 = inst_lui | inst_auipc | inst_jal | grp_load | grp_store;

    always_comb
    begin
        o_ctrl.alu_res.cmp   = grp_branch | ari_cmp | arr_cmp;
        o_ctrl.alu_res.bits  = (grp_ari | grp_arr) & f3_bits;
        o_ctrl.alu_res.shift = (grp_ari & (funct3 == 3'b001))
                             | (grp_ari & (funct3 == 3'b101) & (funct7 == 7'b0000000))
                             | inst_srai
                             | (grp_arr & (funct3[1:0] == 2'b01) & !funct3[2])
                             | (grp_arr & (funct3 == 3'b101))
                             | inst_sra;
        o_ctrl.alu_res.arith = inst_add | inst_sub | grp_load | grp_store;

        o_ctrl.alu_sub[2:0] = no_f3 ? 3'b000 : funct3;
        o_ctrl.alu_sub[3]   = grp_branch & funct3[0];
        // subtract/signed select, funct7[5] covers sub
        if ((opc == `RV_OPC_BRANCH) || inst_sra || inst_srai
            || (((opc == `RV_OPC_OP) || (opc == `RV_OPC_OP_IMM)) && (funct3[2:1] == 2'b01)))
            o_ctrl.alu_sub[4] = 1'b1;
        else if (no_f3 || grp_ari)
            o_ctrl.alu_sub[4] = 1'b0;
        else
            o_ctrl.alu_sub[4] = funct7[5];

        o_ctrl.funct3 = full ? funct3 : 3'b010;

        o_ctrl.res_src.memory  = grp_load;
        o_ctrl.res_src.pc_next = inst_jal | inst_jalr;
        o_ctrl.res_src.alu     = !(grp_load | inst_jal | inst_jalr);

        o_ctrl.op1_src   = inst_auipc | inst_jal;
        o_ctrl.op2_src.j = inst_jal;
        o_ctrl.op2_src.i = inst_jalr | grp_load | grp_ari | inst_lui | inst_auipc | grp_store;
        o_ctrl.op2_src.r = !(inst_jal | inst_jalr | grp_load | grp_ari | inst_lui
                             | inst_auipc | grp_store);

        o_ctrl.reg_write = full & !((opc == `RV_OPC_BRANCH) || (opc == `RV_OPC_STORE)
                                    || (opc == `RV_OPC_STORE_FP));

        o_ctrl.inst_jal     = inst_jal;
        o_ctrl.inst_jalr    = inst_jalr;
        o_ctrl.inst_branch  = grp_branch;
        o_ctrl.inst_store   = grp_store;
        o_ctrl.inst_mret    = inst_mret;
        o_ctrl.inst_ebreak  = inst_ebreak;
        o_ctrl.inst_csr_req = inst_csr_req;

        o_ctrl.supported = grp_load | grp_store | grp_ari | grp_arr | grp_arr_ex
                         | inst_lui | inst_auipc | grp_branch | inst_jal | inst_jalr
                         | inst_ecall | inst_ebreak | inst_csr_req | inst_mret;

        // writeback mux in execute expects one source at most
        assert ($onehot0(o_ctrl.res_src))
            else $error("res_src selects more than one writeback source");
    end

endmodule

//--- rtl/rv_operand_decode.sv
`timescale 1ns/100ps

`include "rv_decode_params.svh"

module rv_operand_decode
    import rv_decode_pkg::*;
(
    input  fetch_t      i_fetch,
    output dec_oper_t   o_oper
);

    logic [`RV_XLEN-1:0]    instr;
    logic [4:0]             opc;
    logic                   full;
    logic                   inst_lui;
    logic                   inst_auipc;
    logic                   inst_jal;
    logic                   inst_store;

    logic [`RV_XLEN-1:0]    imm_i;
    logic [`RV_XLEN-1:0]    imm_s;
    logic [`RV_XLEN-1:0]    imm_b;
    logic [`RV_XLEN-1:0]    imm_u;
    logic [`RV_XLEN-1:0]    imm_j;

    assign instr = i_fetch.instr;
    assign opc   = instr[6:2];
    assign full  = (instr[1:0] == `RV_OPC_FULL);

    assign inst_lui   = full & (opc == `RV_OPC_LUI);
    assign inst_auipc = full & (opc == `RV_OPC_AUIPC);
    assign inst_jal   = full & (opc == `RV_OPC_JAL);
    assign inst_store = full & (opc == `RV_OPC_STORE);

    // sign bit is always instr[31]
    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign o_oper.rd  = instr[11:7];
    assign o_oper.rs2 = instr[24:20];
    // lui reads x0 so the alu adds zero
    assign o_oper.rs1 = inst_lui ? '0 : instr[19:15];

    always_comb
    begin
        if (inst_lui || inst_auipc)
            o_oper.imm_i = imm_u;
        else if (inst_store)
            o_oper.imm_i = imm_s;
        else
            o_oper.imm_i = imm_i;
    end

    assign o_oper.imm_j = inst_jal ? imm_j : imm_b;

    // compressed instructions are two bytes long
    assign o_oper.pc_next = i_fetch.pc + (i_fetch.is_compressed ? `RV_IADDR_BITS'd2
                                                                 : `RV_IADDR_BITS'd4);

    assign o_oper.pc          = i_fetch.pc;
    assign o_oper.branch_pred = i_fetch.branch_pred;

endmodule

//--- rtl/rv_stage_reg.sv
`timescale 1ns/100ps

module rv_stage_reg #(
    parameter type payload_t = logic
)
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_valid,
    input  logic        i_stall,
    input  logic        i_flush,
    input  payload_t    i_data,
    output logic        o_valid,
    output payload_t    o_data
);

    // flush wins over stall
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            o_valid <= 1'b0;
        else if (i_flush)
            o_valid <= 1'b0;
        else if (!i_stall)
            o_valid <= i_valid;
    end

    // payload only moves on acceptance
    always_ff @(posedge i_clk)
    begin
        if (i_valid && !i_stall)
            o_data <= i_data;
    end

    // held output must not change under back-pressure
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_valid && i_stall && !i_flush) |=> (o_valid && $stable(o_data)))
        else $error("stage output changed during stall");

endmodule

//--- rtl/rv_decode_pkg.sv
`include "rv_decode_params.svh"

package rv_decode_pkg;

    // one fetched instruction
    typedef struct packed {
        logic [`RV_XLEN-1:0]        instr;
        logic [`RV_IADDR_BITS-1:0]  pc;
        logic                       branch_pred;
        logic                       is_compressed;
    } fetch_t;

    typedef struct packed {
        logic   cmp;
        logic   bits;
        logic   shift;
        logic   arith;
    } alu_res_t;

    // writeback source, one-hot or zero
    typedef struct packed {
        logic   memory;
        logic   pc_next;
        logic   alu;
    } res_src_t;

    typedef struct packed {
        logic   r;
        logic   i;
        logic   j;
    } op2_src_t;

    typedef struct packed {
        alu_res_t   alu_res;
        logic [4:0] alu_sub;
        logic [2:0] funct3;
        res_src_t   res_src;
        logic       op1_src;
        op2_src_t   op2_src;
        logic       reg_write;
        logic       inst_jal;
        logic       inst_jalr;
        logic       inst_branch;
        logic       inst_store;
        logic       inst_mret;
        logic       inst_ebreak;
        logic       inst_csr_req;
        logic       supported;
    } dec_ctrl_t;

    typedef struct packed {
        logic [`RV_REG_BITS-1:0]    rs1;
        logic [`RV_REG_BITS-1:0]    rs2;
        logic [`RV_REG_BITS-1:0]    rd;
        logic [`RV_XLEN-1:0]        imm_i;
        logic [`RV_XLEN-1:0]        imm_j;
        logic [`RV_IADDR_BITS-1:0]  pc;
        logic [`RV_IADDR_BITS-1:0]  pc_next;
        logic                       branch_pred;
    } dec_oper_t;

    typedef struct packed {
        logic [`RV_CSR_IDX_BITS-1:0]    idx;
        logic [`RV_REG_BITS-1:0]        imm;
        logic                           imm_sel;
        logic                           write;
        logic                           set;
        logic                           clear;
        logic                           read;
    } dec_csr_t;

endpackage

//--- rtl/rv_decode_params.svh
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

`define RV_XLEN             32
`define RV_IADDR_BITS       32
`define RV_REG_BITS         5
`define RV_CSR_IDX_BITS     12

// major opcodes, instr[6:2]
`define RV_OPC_LOAD         5'b00000
`define RV_OPC_OP_IMM       5'b00100
`define RV_OPC_AUIPC        5'b00101
`define RV_OPC_STORE        5'b01000
`define RV_OPC_STORE_FP     5'b01001
`define RV_OPC_OP           5'b01100
`define RV_OPC_LUI          5'b01101
`define RV_OPC_BRANCH       5'b11000
`define RV_OPC_JALR         5'b11001
`define RV_OPC_JAL          5'b11011
`define RV_OPC_SYSTEM       5'b11100

// instr[1:0] of a 32-bit encoding
`define RV_OPC_FULL         2'b11

`define RV_F12_ECALL        12'h000
`define RV_F12_EBREAK       12'h001
`define RV_F12_MRET         12'h302

`endif
